//--- logic/boot_rom.hex
// One 32-bit ROM word per line, word addresses 0 to 15 in order
400000b7
00008093
00100113
0020a023
0000a183
00310233
fe0218e3
c10002b7
0002a303
00130313
0062a023
ff1ff06f
13579bdf
2468ace0
a5a5005a
0000006f

//--- src.f
logic/soc_map_pkg.sv
logic/soc_regs_pkg.sv
logic/bus_decoder.sv
logic/boot_rom.sv
logic/data_ram.sv
logic/timer_core.sv
logic/ctrl_core.sv
logic/app_soc.sv
testbench/tb_app_soc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the app_soc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module tb_app_soc -o tb_app_soc

# A failing run exits nonzero, so its log is kept and searched below
./obj_dir/tb_app_soc > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- testbench/tb_app_soc.sv
// Testbench for the application SoC core

module tb_app_soc;
  timeunit 1ns;
  timeprecision 100ps;

  import soc_map_pkg::*;
  import soc_regs_pkg::*;

  localparam time CLK_PERIOD     = 8ns;
  // Some 200 requests of 3 cycles each need about 5 us
  localparam time WATCHDOG       = 200us;
  localparam int  RESET_CYCLES   = 8;
  localparam int  MAX_WAIT       = 16;
  localparam int  RAM_WORDS_USED = 16;
  localparam int  RAM_WRITES     = 32;

  logic  clk;
  logic  reset_n;
  logic  mem_valid;
  logic  mem_instr;
  addr_t mem_addr;
  data_t mem_wdata;
  strb_t mem_wstrb;
  data_t mem_rdata;
  logic  mem_ready;
  logic  led_r;
  logic  led_g;
  logic  led_b;

  string test_name;
  data_t rom_ref [ROM_WORDS];
  data_t mem_ref [addr_t];
  addr_t fw_probe;

  app_soc dut_i (
    .clk, .reset_n, .mem_valid, .mem_instr, .mem_addr, .mem_wdata, .mem_wstrb,
    .mem_rdata, .mem_ready, .led_r, .led_g, .led_b
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------
  // Helpers
  // --------------------
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  function automatic string error_line(input string name, input data_t expected,
                                       input data_t actual);
    return $sformatf("ERROR %s: expected %h, actual %h", name, expected, actual);
  endfunction

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    assert (actual === expected) else begin
      fail_run(error_line(name, expected, actual));
    end
  endtask

  function automatic addr_t mmio_addr(input core_t core, input reg_addr_t offset);
    return {MMIO_AREA, core, 14'b0, offset, 2'b00};
  endfunction

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t strb);
    data_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  task automatic apply_reset();
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1ns;
    reset_n = 1'b1;
  endtask

  // One request with its latency counted in edges from the drive to mem_ready
  task automatic bus_access(input addr_t addr, input logic instr, input data_t wdata,
                            input strb_t strb, input int latency, output data_t rdata);
    int edges;
    mem_valid = 1'b1;
    mem_instr = instr;
    mem_addr  = addr;
    mem_wdata = wdata;
    mem_wstrb = strb;
    edges     = 0;
    do begin
      @(posedge clk);
      #1ns;
      edges++;
      if (edges > MAX_WAIT) begin
        fail_run($sformatf("No mem_ready in %s for address %h", test_name, addr));
      end
    end while (!mem_ready);
    rdata = mem_rdata;
    check_value({test_name, "/latency"}, data_t'(latency), data_t'(edges));
    @(posedge clk);
    #1ns;
    mem_valid = 1'b0;
    mem_instr = 1'b0;
    mem_wstrb = '0;
  endtask

  task automatic bus_read(input addr_t addr, input logic instr, input int latency,
                          output data_t rdata);
    bus_access(addr, instr, '0, 4'h0, latency, rdata);
  endtask

  task automatic bus_write(input addr_t addr, input data_t wdata, input strb_t strb,
                           input int latency);
    data_t unused_rdata;
    bus_access(addr, 1'b0, wdata, strb, latency, unused_rdata);
  endtask

  task automatic ram_random_test(input addr_t base, input int addr_w);
    addr_t used [$];
    addr_t addr;
    data_t wdata;
    data_t rdata;
    strb_t strb;
    // Full words first so every byte of the model is known
    for (int n = 0; n < RAM_WORDS_USED; n++) begin
      addr  = base | (addr_t'($urandom_range(0, (1 << addr_w) - 1)) << 2);
      wdata = $urandom();
      bus_write(addr, wdata, 4'hf, 2);
      mem_ref[addr] = wdata;
      used.push_back(addr);
    end
    for (int n = 0; n < RAM_WRITES; n++) begin
      addr  = used[$urandom_range(0, RAM_WORDS_USED - 1)];
      wdata = $urandom();
      strb  = strb_t'($urandom_range(1, 15));
      bus_write(addr, wdata, strb, 2);
      mem_ref[addr] = merge_bytes(mem_ref[addr], wdata, strb);
    end
    foreach (used[n]) begin
      bus_read(used[n], 1'b0, 2, rdata);
      check_value(test_name, mem_ref[used[n]], rdata);
    end
  endtask

  // Each answer lasts exactly one cycle
  ready_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    !(mem_ready && $past(mem_ready)))
    else fail_run(error_line({test_name, "/ready_pulse"}, 32'd0, 32'd1));

  initial begin
    #(WATCHDOG);
    fail_run("Watchdog expired before the tests finished");
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    data_t rdata;
    void'($urandom(68));
    clk       = 1'b0;
    reset_n   = 1'b0;
    mem_valid = 1'b0;
    mem_instr = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    $readmemh("logic/boot_rom.hex", rom_ref);
    apply_reset();

    test_name = "reset_state";
    check_value(test_name, 32'd0, data_t'(mem_ready));
    check_value(test_name, 32'd0, {29'b0, led_r, led_g, led_b});
    test_name = "reserved_area";
    bus_read(32'h8000_0040, 1'b0, 1, rdata);
    check_value(test_name, 32'd0, rdata);
    test_name = "unmapped_core";
    bus_read(mmio_addr(6'h02, 8'h00), 1'b0, 1, rdata);
    check_value(test_name, 32'd0, rdata);

    // Boot ROM
    test_name = "rom_read";
    for (int i = 0; i < ROM_WORDS; i++) begin
      bus_read(addr_t'(i) << 2, 1'b0, 2, rdata);
      check_value(test_name, rom_ref[i], rdata);
    end
    test_name = "rom_fetch_fw";
    bus_read(32'h0000_0004, 1'b1, 2, rdata);
    check_value(test_name, rom_ref[1], rdata);
    test_name = "rom_write";
    bus_write(32'h0000_0008, 32'hdead_beef, 4'hf, 2);
    bus_read(32'h0000_0008, 1'b0, 2, rdata);
    check_value(test_name, rom_ref[2], rdata);

    test_name = "app_ram";
    ram_random_test({RAM_AREA, 30'b0}, RAM_ADDR_W);
    test_name = "fw_ram";
    ram_random_test(mmio_addr(FW_RAM_CORE, 8'h00), FW_RAM_ADDR_W);

    // Timer runs 10 ticks of 4 cycles
    test_name = "timer_setup";
    bus_write(mmio_addr(TIMER_CORE, TIMER_PRESCALER), 32'd4, 4'hf, 2);
    bus_write(mmio_addr(TIMER_CORE, TIMER_VALUE), 32'd10, 4'hf, 2);
    bus_read(mmio_addr(TIMER_CORE, TIMER_PRESCALER), 1'b0, 2, rdata);
    check_value(test_name, 32'd4, rdata);
    bus_write(mmio_addr(TIMER_CORE, TIMER_CTRL), 32'd1, 4'hf, 2);
    test_name = "timer_running";
    bus_read(mmio_addr(TIMER_CORE, TIMER_STATUS), 1'b0, 2, rdata);
    check_value(test_name, 32'd1, rdata);
    bus_write(mmio_addr(TIMER_CORE, TIMER_VALUE), 32'd99, 4'hf, 2);
    repeat (48) @(posedge clk);
    #1ns;
    test_name = "timer_expired";
    bus_read(mmio_addr(TIMER_CORE, TIMER_STATUS), 1'b0, 2, rdata);
    check_value(test_name, 32'd0, rdata);
    bus_read(mmio_addr(TIMER_CORE, TIMER_VALUE), 1'b0, 2, rdata);
    check_value(test_name, 32'd0, rdata);

    // LEDs and the switch to application mode
    test_name = "led_write";
    bus_write(mmio_addr(CTRL_CORE, CTRL_LED), 32'd5, 4'hf, 2);
    check_value(test_name, 32'h5, {29'b0, led_r, led_g, led_b});
    test_name = "mode_firmware";
    fw_probe = mmio_addr(FW_RAM_CORE, 8'h11);
    bus_write(fw_probe, 32'h600d_f00d, 4'hf, 2);
    mem_ref[fw_probe] = 32'h600d_f00d;
    bus_read(mmio_addr(CTRL_CORE, CTRL_SYSTEM_MODE), 1'b0, 2, rdata);
    check_value(test_name, 32'd0, rdata);
    test_name = "mode_switch";
    bus_write(mmio_addr(CTRL_CORE, CTRL_SWITCH_APP), 32'd1, 4'hf, 2);
    bus_read(mmio_addr(CTRL_CORE, CTRL_SYSTEM_MODE), 1'b0, 2, rdata);
    check_value(test_name, 32'd1, rdata);
    test_name = "fw_ram_hidden";
    bus_read(fw_probe, 1'b0, 1, rdata);
    check_value(test_name, 32'd0, rdata);
    bus_write(fw_probe, 32'hbad0_bad0, 4'hf, 1);
    test_name = "rom_fetch_trap";
    bus_read(32'h0000_000c, 1'b1, 1, rdata);
    check_value(test_name, 32'd0, rdata);
    test_name = "rom_data_app";
    bus_read(32'h0000_000c, 1'b0, 2, rdata);
    check_value(test_name, rom_ref[3], rdata);

    // Lost write must stay unseen after reset to firmware mode
    apply_reset();
    test_name = "fw_ram_kept";
    bus_read(mmio_addr(CTRL_CORE, CTRL_SYSTEM_MODE), 1'b0, 2, rdata);
    check_value(test_name, 32'd0, rdata);
    bus_read(fw_probe, 1'b0, 2, rdata);
    check_value(test_name, mem_ref[fw_probe], rdata);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- logic/app_soc.sv
// Application SoC memory-mapped core

module app_soc (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               mem_valid,
  input  logic               mem_instr,
  input  soc_map_pkg::addr_t mem_addr,
  input  soc_map_pkg::data_t mem_wdata,
  input  soc_map_pkg::strb_t mem_wstrb,
  output soc_map_pkg::data_t mem_rdata,
  output logic               mem_ready,
  output logic               led_r,
  output logic               led_g,
  output logic               led_b
);
  import soc_map_pkg::*;
  import soc_regs_pkg::*;

  logic                         rom_cs, ram_cs, fw_ram_cs, timer_cs, ctrl_cs;
  logic                         rom_ready, ram_ready, fw_ram_ready, timer_ready, ctrl_ready;
  data_t                        rom_read_data, ram_read_data, fw_ram_read_data;
  data_t                        timer_read_data, ctrl_read_data;
  strb_t                        ram_we, fw_ram_we;
  logic                         reg_we;
  reg_addr_t                    reg_address;
  logic [RAM_ADDR_W-1:0]        ram_address;
  logic [FW_RAM_ADDR_W-1:0]     fw_ram_address;
  logic [$clog2(ROM_WORDS)-1:0] rom_address;
  data_t                        write_data;
  logic                         system_mode;
  logic                         force_trap;

  bus_decoder decoder_i (
    .clk, .reset_n, .mem_valid, .mem_addr, .mem_wdata, .mem_wstrb,
    .system_mode, .force_trap,
    .rom_cs, .rom_read_data, .rom_ready,
    .ram_cs, .ram_read_data, .ram_ready,
    .fw_ram_cs, .fw_ram_read_data, .fw_ram_ready,
    .timer_cs, .timer_read_data, .timer_ready,
    .ctrl_cs, .ctrl_read_data, .ctrl_ready,
    .ram_we, .fw_ram_we, .reg_we, .reg_address,
    .ram_address, .fw_ram_address, .rom_address, .write_data,
    .mem_rdata, .mem_ready
  );

  boot_rom rom_i (
    .clk, .reset_n, .cs(rom_cs), .address(rom_address),
    .read_data(rom_read_data), .ready(rom_ready)
  );

  // --------------------
  // RAMs
  // --------------------
  data_ram #(.ADDR_W(RAM_ADDR_W)) ram_i (
    .clk, .reset_n, .cs(ram_cs), .we(ram_we), .address(ram_address),
    .write_data, .read_data(ram_read_data), .ready(ram_ready)
  );

  data_ram #(.ADDR_W(FW_RAM_ADDR_W)) fw_ram_i (
    .clk, .reset_n, .cs(fw_ram_cs), .we(fw_ram_we), .address(fw_ram_address),
    .write_data, .read_data(fw_ram_read_data), .ready(fw_ram_ready)
  );

  timer_core timer_i (
    .clk, .reset_n, .cs(timer_cs), .we(reg_we), .address(reg_address),
    .write_data, .read_data(timer_read_data), .ready(timer_ready)
  );

  ctrl_core ctrl_i (
    .clk, .reset_n, .cs(ctrl_cs), .we(reg_we), .address(reg_address),
    .write_data, .mem_valid, .mem_instr, .mem_addr,
    .read_data(ctrl_read_data), .ready(ctrl_ready),
    .system_mode, .force_trap, .led_r, .led_g, .led_b
  );

endmodule

//--- logic/ctrl_core.sv
// System control with mode switch, LEDs and fetch trap

module ctrl_core (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    cs,
  input  logic                    we,
  input  soc_regs_pkg::reg_addr_t address,
  input  soc_map_pkg::data_t      write_data,
  input  logic                    mem_valid,
  input  logic                    mem_instr,
  input  soc_map_pkg::addr_t      mem_addr,
  output soc_map_pkg::data_t      read_data,
  output logic                    ready,
  output logic                    system_mode,
  output logic                    force_trap,
  output logic                    led_r,
  output logic                    led_g,
  output logic                    led_b
);
  import soc_map_pkg::*;
  import soc_regs_pkg::*;

  led_t  led;
  area_t fetch_area;

  assign fetch_area = mem_addr[31:30];

  // Applications may not run code out of the boot ROM
  assign force_trap = system_mode && mem_valid && mem_instr && (fetch_area == ROM_AREA);

  assign led_r = led[2];
  assign led_g = led[1];
  assign led_b = led[0];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      system_mode <= 1'b0;
      led         <= '0;
      ready       <= 1'b0;
    end else begin
      ready <= cs;
      if (cs && we) begin
        // One way switch cleared by reset alone
        if (address == CTRL_SWITCH_APP) begin
          system_mode <= 1'b1;
        end
        if (address == CTRL_LED) begin
          led <= write_data[2:0];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    case (address)
      CTRL_SYSTEM_MODE: read_data <= {31'b0, system_mode};
      CTRL_LED:         read_data <= {29'b0, led};
      default:          read_data <= '0;
    endcase
  end

endmodule

//--- logic/timer_core.sv
// Prescaled down-counting timer

module timer_core (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    cs,
  input  logic                    we,
  input  soc_regs_pkg::reg_addr_t address,
  input  soc_map_pkg::data_t      write_data,
  output soc_map_pkg::data_t      read_data,
  output logic                    ready
);
  import soc_map_pkg::*;
  import soc_regs_pkg::*;

  logic  running;
  data_t prescaler;
  data_t value;
  data_t tick_ctr;
  logic  tick_done;
  logic  wr;

  assign wr = cs && we;

  // Also true for a prescaler of 0 or 1
  assign tick_done = (tick_ctr + 32'd1) >= prescaler;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      running   <= 1'b0;
      prescaler <= '0;
      value     <= '0;
      tick_ctr  <= '0;
      ready     <= 1'b0;
    end else begin
      ready <= cs;

      if (running) begin
        if (tick_done) begin
          tick_ctr <= '0;
          value    <= value - 32'd1;
          if (value == 32'd1) begin
            running <= 1'b0;
          end
        end else begin
          tick_ctr <= tick_ctr + 32'd1;
        end
      end

      // Setup registers frozen while counting
      if (wr && !running && address == TIMER_PRESCALER) begin
        prescaler <= write_data;
      end
      if (wr && !running && address == TIMER_VALUE) begin
        value <= write_data;
      end

      // Stop wins over start
      if (wr && address == TIMER_CTRL) begin
        if (write_data[1]) begin
          running <= 1'b0;
        end else if (write_data[0] && value != '0) begin
          running  <= 1'b1;
          tick_ctr <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    case (address)
      TIMER_STATUS:    read_data <= {31'b0, running};
      TIMER_PRESCALER: read_data <= prescaler;
      TIMER_VALUE:     read_data <= value;
      default:         read_data <= '0;
    endcase
  end

endmodule

//--- logic/data_ram.sv
// Byte-writable word RAM

module data_ram #(
  parameter int ADDR_W = 10
) (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               cs,
  input  soc_map_pkg::strb_t we,
  input  logic [ADDR_W-1:0]  address,
  input  soc_map_pkg::data_t write_data,
  output soc_map_pkg::data_t read_data,
  output logic               ready
);
  import soc_map_pkg::*;

  localparam int DEPTH = 2 ** ADDR_W;

  data_t mem [DEPTH];

  // One enable per byte lane
  always_ff @(posedge clk) begin
    if (cs) begin
      for (int i = 0; i < 4; i++) begin
        if (we[i]) begin
          mem[address][8*i +: 8] <= write_data[8*i +: 8];
        end
      end
    end
    read_data <= mem[address];
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready <= 1'b0;
    end else begin
      ready <= cs;
    end
  end

endmodule

//--- logic/boot_rom.sv
// Boot ROM

module boot_rom (
  input  logic                                      clk,
  input  logic                                      reset_n,
  input  logic                                      cs,
  input  logic [$clog2(soc_map_pkg::ROM_WORDS)-1:0] address,
  output soc_map_pkg::data_t                        read_data,
  output logic                                      ready
);
  import soc_map_pkg::*;

  data_t mem [ROM_WORDS];

  // Contents fixed at build time
  initial begin
    $readmemh("logic/boot_rom.hex", mem);
  end

  always_ff @(posedge clk) begin
    read_data <= mem[address];
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready <= 1'b0;
    end else begin
      ready <= cs;
    end
  end

endmodule

//--- logic/bus_decoder.sv
// Bus decoder with registered response mux

module bus_decoder (
  input  logic                                      clk,
  input  logic                                      reset_n,
  input  logic                                      mem_valid,
  input  soc_map_pkg::addr_t                        mem_addr,
  input  soc_map_pkg::data_t                        mem_wdata,
  input  soc_map_pkg::strb_t                        mem_wstrb,
  input  logic                                      system_mode,
  input  logic                                      force_trap,
  output logic                                      rom_cs,
  input  soc_map_pkg::data_t                        rom_read_data,
  input  logic                                      rom_ready,
  output logic                                      ram_cs,
  input  soc_map_pkg::data_t                        ram_read_data,
  input  logic                                      ram_ready,
  output logic                                      fw_ram_cs,
  input  soc_map_pkg::data_t                        fw_ram_read_data,
  input  logic                                      fw_ram_ready,
  output logic                                      timer_cs,
  input  soc_map_pkg::data_t                        timer_read_data,
  input  logic                                      timer_ready,
  output logic                                      ctrl_cs,
  input  soc_map_pkg::data_t                        ctrl_read_data,
  input  logic                                      ctrl_ready,
  output soc_map_pkg::strb_t                        ram_we,
  output soc_map_pkg::strb_t                        fw_ram_we,
  output logic                                      reg_we,
  output soc_regs_pkg::reg_addr_t                   reg_address,
  output logic [soc_map_pkg::RAM_ADDR_W-1:0]        ram_address,
  output logic [soc_map_pkg::FW_RAM_ADDR_W-1:0]     fw_ram_address,
  output logic [$clog2(soc_map_pkg::ROM_WORDS)-1:0] rom_address,
  output soc_map_pkg::data_t                        write_data,
  output soc_map_pkg::data_t                        mem_rdata,
  output logic                                      mem_ready
);
  import soc_map_pkg::*;

  area_t area;
  core_t core;
  data_t rdata_next;
  logic  ready_next;

  assign area = mem_addr[31:30];
  assign core = mem_addr[29:24];

  // Fields shared by all cores
  assign reg_we         = |mem_wstrb;
  assign reg_address    = mem_addr[9:2];
  assign ram_address    = mem_addr[2 +: RAM_ADDR_W];
  assign fw_ram_address = mem_addr[2 +: FW_RAM_ADDR_W];
  assign rom_address    = mem_addr[2 +: $clog2(ROM_WORDS)];
  assign write_data     = mem_wdata;

  // --------------------
  // Select and response mux
  // --------------------
  always_comb begin
    rom_cs     = 1'b0;
    ram_cs     = 1'b0;
    fw_ram_cs  = 1'b0;
    timer_cs   = 1'b0;
    ctrl_cs    = 1'b0;
    ram_we     = '0;
    fw_ram_we  = '0;
    rdata_next = '0;
    ready_next = 1'b0;

    // Held off while the previous answer is on the port
    if (mem_valid && !mem_ready) begin
      if (force_trap) begin
        rdata_next = ILLEGAL_INSTRUCTION;
        ready_next = 1'b1;
      end else begin
        // Unmapped targets answer zero at once
        ready_next = 1'b1;
        case (area)
          ROM_AREA: begin
            rom_cs     = 1'b1;
            rdata_next = rom_read_data;
            ready_next = rom_ready;
          end
          RAM_AREA: begin
            ram_cs     = 1'b1;
            ram_we     = mem_wstrb;
            rdata_next = ram_read_data;
            ready_next = ram_ready;
          end
          MMIO_AREA: begin
            case (core)
              TIMER_CORE: begin
                timer_cs   = 1'b1;
                rdata_next = timer_read_data;
                ready_next = timer_ready;
              end
              FW_RAM_CORE: begin
                // Hidden once in application mode
                if (!system_mode) begin
                  fw_ram_cs  = 1'b1;
                  fw_ram_we  = mem_wstrb;
                  rdata_next = fw_ram_read_data;
                  ready_next = fw_ram_ready;
                end
              end
              CTRL_CORE: begin
                ctrl_cs    = 1'b1;
                rdata_next = ctrl_read_data;
                ready_next = ctrl_ready;
              end
              default: ;
            endcase
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mem_rdata <= '0;
      mem_ready <= 1'b0;
    end else begin
      mem_rdata <= rdata_next;
      mem_ready <= ready_next;
    end
  end

endmodule

//--- logic/soc_regs_pkg.sv
// Register map of the timer and control cores

package soc_regs_pkg;

  // Word offset inside a core from address bits 9:2
  typedef logic [7:0] reg_addr_t;

  // LED bits with red on bit 2
  typedef logic [2:0] led_t;

  // --------------------
  // Timer
  // --------------------
  localparam reg_addr_t TIMER_CTRL      = 8'h08;
  localparam reg_addr_t TIMER_STATUS    = 8'h09;
  localparam reg_addr_t TIMER_PRESCALER = 8'h0a;
  localparam reg_addr_t TIMER_VALUE     = 8'h0b;

  // --------------------
  // Control
  // --------------------
  localparam reg_addr_t CTRL_SWITCH_APP  = 8'h08;
  localparam reg_addr_t CTRL_SYSTEM_MODE = 8'h09;
  localparam reg_addr_t CTRL_LED         = 8'h0a;

endpackage

//--- logic/soc_map_pkg.sv
// Bus address map and word types

package soc_map_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  area_t;
  typedef logic [5:0]  core_t;

  // Top level areas in address bits 31:30
  localparam area_t ROM_AREA      = 2'h0;
  localparam area_t RAM_AREA      = 2'h1;
  localparam area_t RESERVED_AREA = 2'h2;
  localparam area_t MMIO_AREA     = 2'h3;

  // MMIO cores in address bits 29:24
  localparam core_t TIMER_CORE  = 6'h01;
  localparam core_t FW_RAM_CORE = 6'h10;
  localparam core_t CTRL_CORE   = 6'h3f;

  // Memory sizes
  localparam int ROM_WORDS     = 16;
  localparam int RAM_ADDR_W    = 10;
  localparam int FW_RAM_ADDR_W = 7;

  // Returned on a forced trap
  localparam data_t ILLEGAL_INSTRUCTION = 32'h0;

endpackage
